/* verilog/adc_rx_pkg.sv */
`default_nettype none

package adc_rx_pkg;

  localparam int NUM_CHIPS      = 2;
  localparam int CH_PER_CHIP    = 4;
  localparam int NUM_CH         = NUM_CHIPS * CH_PER_CHIP;
  localparam int WORD_W         = 12;
  localparam int BITS_PER_CLK   = 2;
  localparam int CLKS_PER_FRAME = WORD_W / BITS_PER_CLK;
  localparam int CNT_W          = $clog2(CLKS_PER_FRAME + 1);

  // Frame clock bits over one frame with the earliest bit in the MSB.
  localparam logic [WORD_W-1:0] FRAME_PATTERN = 12'b1111_1100_0000;

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // One chip for one adc_clk cycle. Rise bit is the earlier of each pair.
  typedef struct packed {
    logic [CH_PER_CHIP-1:0] data_rise;
    logic [CH_PER_CHIP-1:0] data_fall;
    logic                   frame_rise;
    logic                   frame_fall;
  } adc_ddr_t;

  // Raw offset binary words of one chip.
  typedef struct packed {
    logic [CH_PER_CHIP-1:0][WORD_W-1:0] word;
  } chip_words_t;

  typedef logic signed [WORD_W-1:0] sample_t;

  // Two's complement samples with chip 0 in the low channels.
  typedef struct packed {
    sample_t [NUM_CH-1:0] ch;
  } sample_vec_t;

  typedef enum logic {
    LOCK_HUNT,
    LOCK_HELD
  } lock_state_e;

endpackage

`default_nettype wire

/* verilog/adc_lane_deserialise.sv */
`default_nettype none

module adc_lane_deserialise import adc_rx_pkg::*; (
  input  logic        adc_clk,
  input  logic        rst_n,
  input  adc_ddr_t    ddr_in,
  output chip_words_t words,
  output logic        word_valid
);

  logic [CH_PER_CHIP-1:0][WORD_W-1:0] shift_q;
  logic [CH_PER_CHIP-1:0][WORD_W-1:0] shift_d;
  logic                               fall_q;
  logic                               frame_start;
  logic [CNT_W-1:0]                   pair_cnt;
  logic                               frame_end;

  // Rising frame clock with the previous fall bit low.
  assign frame_start = ddr_in.frame_rise & ~fall_q;
  assign frame_end   = ~frame_start && (pair_cnt == CNT_W'(CLKS_PER_FRAME - 1));

  always_comb begin
    for (int l = 0; l < CH_PER_CHIP; l++) begin
      shift_d[l] = {shift_q[l][WORD_W-BITS_PER_CLK-1:0],
                    ddr_in.data_rise[l], ddr_in.data_fall[l]};
    end
  end

  always_ff @(posedge adc_clk) begin
    shift_q <= shift_d;
    if (frame_end) begin
      words.word <= shift_d; // Sixth pair goes straight into the word.
    end
  end

  // Pairs taken so far. CLKS_PER_FRAME means idle.
  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      fall_q     <= 1'b0;
      pair_cnt   <= CNT_W'(CLKS_PER_FRAME);
      word_valid <= 1'b0;
    end else begin
      fall_q     <= ddr_in.frame_fall;
      word_valid <= frame_end;
      if (frame_start) begin
        pair_cnt <= CNT_W'(1);
      end else if (pair_cnt < CNT_W'(CLKS_PER_FRAME)) begin
        pair_cnt <= pair_cnt + 1'b1;
      end
    end
  end

  a_valid_spacing: assert property (
    @(posedge adc_clk) disable iff (!rst_n)
    word_valid |=> !word_valid
  );

endmodule

`default_nettype wire

/* verilog/adc_frame_monitor.sv */
`default_nettype none

module adc_frame_monitor import adc_rx_pkg::*; (
  input  logic     adc_clk,
  input  logic     rst_n,
  input  adc_ddr_t ddr_in,
  output logic     frame_locked
);

  lock_state_e       state;
  logic [WORD_W-1:0] pattern_q;
  logic              fall_q;
  logic              frame_start;
  logic              good_seen;
  logic [CNT_W-1:0]  gap_cnt;
  logic              boundary_lost;

  assign frame_start   = ddr_in.frame_rise & ~fall_q;
  assign boundary_lost = ~frame_start && (gap_cnt == CNT_W'(CLKS_PER_FRAME));
  assign frame_locked  = (state == LOCK_HELD);

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= LOCK_HUNT;
      pattern_q <= '0;
      fall_q    <= 1'b0;
      good_seen <= 1'b0;
      gap_cnt   <= '0;
    end else begin
      fall_q    <= ddr_in.frame_fall;
      pattern_q <= {pattern_q[WORD_W-BITS_PER_CLK-1:0], ddr_in.frame_rise, ddr_in.frame_fall};
      if (frame_start) begin
        gap_cnt <= CNT_W'(1);
        if (pattern_q == FRAME_PATTERN) begin // Last twelve bits are the frame just ended.
          good_seen <= 1'b1;
          if (good_seen) begin
            state <= LOCK_HELD;
          end
        end else begin
          good_seen <= 1'b0;
          state     <= LOCK_HUNT;
        end
      end else begin
        if (gap_cnt != '1) begin
          gap_cnt <= gap_cnt + 1'b1;
        end
        if (boundary_lost) begin // No frame edge where one was due.
          good_seen <= 1'b0;
          state     <= LOCK_HUNT;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/adc_retime_fifo.sv */
`default_nettype none

module adc_retime_fifo import adc_rx_pkg::*; (
  input  logic        adc_clk,
  input  logic        fab_clk,
  input  logic        rst_n,
  input  chip_words_t wr_data,
  input  logic        wr_en,
  output chip_words_t rd_data,
  input  logic        rd_en,
  output logic        empty,
  output logic        overflow
);

  typedef logic [FIFO_AW:0] ptr_t;

  chip_words_t mem [FIFO_DEPTH];

  ptr_t wr_bin;
  ptr_t wr_bin_next;
  ptr_t wr_gray;
  ptr_t rd_bin;
  ptr_t rd_bin_next;
  ptr_t rd_gray;
  ptr_t rd_gray_s1;
  ptr_t rd_gray_s2;
  ptr_t wr_gray_s1;
  ptr_t wr_gray_s2;
  logic full;

  function automatic ptr_t bin2gray(input ptr_t b);
    return b ^ (b >> 1);
  endfunction

  assign wr_bin_next = wr_bin + 1'b1;
  assign rd_bin_next = rd_bin + 1'b1;

  // Full when the read pointer is one lap behind.
  assign full    = (wr_gray == {~rd_gray_s2[FIFO_AW -: 2], rd_gray_s2[FIFO_AW-2:0]});
  assign empty   = (rd_gray == wr_gray_s2);
  assign rd_data = mem[rd_bin[FIFO_AW-1:0]]; // Show-ahead head entry.

  always_ff @(posedge adc_clk) begin
    if (wr_en && !full) begin
      mem[wr_bin[FIFO_AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge adc_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
      overflow   <= 1'b0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
      if (wr_en && !full) begin
        wr_bin  <= wr_bin_next;
        wr_gray <= bin2gray(wr_bin_next);
      end
      if (wr_en && full) begin
        overflow <= 1'b1; // Word dropped. Flag holds until reset.
      end
    end
  end

  always_ff @(posedge fab_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
      if (rd_en && !empty) begin
        rd_bin  <= rd_bin_next;
        rd_gray <= bin2gray(rd_bin_next);
      end
    end
  end

  // Pop comes from the aligner, which sees every chip's empty flag.
  a_no_pop_empty: assert property (
    @(posedge fab_clk) disable iff (!rst_n)
    rd_en |-> !empty
  );

endmodule

`default_nettype wire

/* verilog/adc_sample_align.sv */
`default_nettype none

module adc_sample_align import adc_rx_pkg::*; (
  input  logic                        fab_clk,
  input  logic                        rst_n,
  input  chip_words_t [NUM_CHIPS-1:0] chip_words,
  input  logic [NUM_CHIPS-1:0]        fifo_empty,
  output logic                        pop,
  output sample_vec_t                 samples,
  output logic                        sample_valid
);

  sample_vec_t converted;

  assign pop = ~|fifo_empty; // All chips have a frame ready.

  // Offset binary to two's complement by flipping the MSB.
  always_comb begin
    for (int c = 0; c < NUM_CHIPS; c++) begin
      for (int k = 0; k < CH_PER_CHIP; k++) begin
        converted.ch[c*CH_PER_CHIP + k] = {~chip_words[c].word[k][WORD_W-1],
                                           chip_words[c].word[k][WORD_W-2:0]};
      end
    end
  end

  always_ff @(posedge fab_clk) begin
    if (pop) begin
      samples <= converted;
    end
  end

  always_ff @(posedge fab_clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= pop;
    end
  end

endmodule

`default_nettype wire

/* verilog/adc_rx_top.sv */
`default_nettype none

module adc_rx_top import adc_rx_pkg::*; (
  input  logic                     adc_clk,
  input  logic                     fab_clk,
  input  logic                     rst_n,
  input  adc_ddr_t [NUM_CHIPS-1:0] ddr_in,
  output sample_vec_t              samples,
  output logic                     sample_valid,
  output logic [NUM_CHIPS-1:0]     frame_locked,
  output logic [NUM_CHIPS-1:0]     fifo_overflow
);

  chip_words_t [NUM_CHIPS-1:0] lane_words;
  logic [NUM_CHIPS-1:0]        lane_valid;
  chip_words_t [NUM_CHIPS-1:0] fifo_data;
  logic [NUM_CHIPS-1:0]        fifo_empty;
  logic                        pop;

  for (genvar c = 0; c < NUM_CHIPS; c++) begin : g_chip
    adc_lane_deserialise u_deser (
      .adc_clk    (adc_clk),
      .rst_n      (rst_n),
      .ddr_in     (ddr_in[c]),
      .words      (lane_words[c]),
      .word_valid (lane_valid[c])
    );

    adc_frame_monitor u_fmon (
      .adc_clk      (adc_clk),
      .rst_n        (rst_n),
      .ddr_in       (ddr_in[c]),
      .frame_locked (frame_locked[c])
    );

    adc_retime_fifo u_fifo (
      .adc_clk  (adc_clk),
      .fab_clk  (fab_clk),
      .rst_n    (rst_n),
      .wr_data  (lane_words[c]),
      .wr_en    (lane_valid[c]),
      .rd_data  (fifo_data[c]),
      .rd_en    (pop), // Shared pop keeps the chips aligned.
      .empty    (fifo_empty[c]),
      .overflow (fifo_overflow[c])
    );
  end

  adc_sample_align u_align (
    .fab_clk      (fab_clk),
    .rst_n        (rst_n),
    .chip_words   (fifo_data),
    .fifo_empty   (fifo_empty),
    .pop          (pop),
    .samples      (samples),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD = 10
) (
  input  logic en,
  output logic clk
);

  // Each period starts low. Held low while disabled.
  always begin
    if (en) begin
      clk = 1'b0;
      #(PERIOD / 2);
      clk = 1'b1;
      #(PERIOD - PERIOD / 2);
    end else begin
      clk = 1'b0;
      wait (en);
    end
  end

endmodule

`default_nettype wire

/* dv/adc_rx_checker.sv */
`default_nettype none

module adc_rx_checker import adc_rx_pkg::*; (
  input logic        fab_clk,
  input logic        rst_n,
  input sample_vec_t samples,
  input logic        sample_valid,
  input logic        compare_en
);

  sample_vec_t exp_q[$];
  int          n_rows     = 0;
  int          err_cnt    = 0;
  int          n_checks   = 0;
  int          n_tests    = 0;
  int          n_failed   = 0;
  int          test_base  = 0;

  task automatic push_expected(input sample_vec_t v);
    exp_q.push_back(v);
  endtask

  task automatic expect_bits(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      err_cnt++;
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = err_cnt - test_base;
    n_tests++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      n_failed++;
      $display("test %s: %0d errors", name, errs);
    end
    test_base = err_cnt;
  endtask

  task automatic summary();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, err_cnt);
  endtask

  // Every output row is compared in order against the queue.
  always @(posedge fab_clk) begin
    sample_vec_t exp_v;
    if (rst_n && sample_valid && compare_en) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("sample_valid rose with no expected row left");
      end else begin
        exp_v = exp_q.pop_front();
        for (int i = 0; i < NUM_CH; i++) begin
          n_checks++;
          if (samples.ch[i] !== exp_v.ch[i]) begin
            err_cnt++;
            $display("error samples.ch[%0d] row %0d got 0x%03h expected 0x%03h",
                     i, n_rows, samples.ch[i], exp_v.ch[i]);
          end
        end
        n_rows++;
      end
    end
  end

endmodule

`default_nettype wire

/* dv/adc_rx_tb.sv */
`default_nettype none

module adc_rx_tb import adc_rx_pkg::*; ();

  localparam int NUM_ROWS = 32;
  localparam logic [WORD_W-1:0] BAD_PATTERN = 12'b1111_0000_0000;
  localparam logic [WORD_W-1:0] MIDSCALE    = 1 << (WORD_W - 1);

  logic                     adc_clk;
  logic                     fab_clk;
  logic                     fab_en;
  logic                     rst_n;
  adc_ddr_t [NUM_CHIPS-1:0] ddr_in;
  sample_vec_t              samples;
  logic                     sample_valid;
  logic [NUM_CHIPS-1:0]     frame_locked;
  logic [NUM_CHIPS-1:0]     fifo_overflow;

  logic [WORD_W-1:0] raw [NUM_ROWS][NUM_CH];
  logic              stream_on;
  logic              compare_en;
  logic              lock1_lost;
  int                cyc;
  int                bad_frame;
  int                skew [NUM_CHIPS];
  logic [31:0]       rng;
  int                local_cyc;
  int                f;
  int                p;
  logic [WORD_W-1:0] pat;
  logic [WORD_W-1:0] w;

  tb_clock_gen #(.PERIOD(10)) adc_clk_gen (.en(1'b1), .clk(adc_clk));
  tb_clock_gen #(.PERIOD(7))  fab_clk_gen (.en(fab_en), .clk(fab_clk));

  adc_rx_top uut (
    .adc_clk       (adc_clk),
    .fab_clk       (fab_clk),
    .rst_n         (rst_n),
    .ddr_in        (ddr_in),
    .samples       (samples),
    .sample_valid  (sample_valid),
    .frame_locked  (frame_locked),
    .fifo_overflow (fifo_overflow)
  );

  adc_rx_checker chk (
    .fab_clk      (fab_clk),
    .rst_n        (rst_n),
    .samples      (samples),
    .sample_valid (sample_valid),
    .compare_en   (compare_en)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [WORD_W-1:0] frame_word(input int fi, input int ch);
    if (fi < NUM_ROWS) begin
      return raw[fi][ch];
    end
    return WORD_W'(fi * 37 + ch); // Filler after the table.
  endfunction

  function automatic sample_vec_t expected_row(input int fi);
    sample_vec_t v;
    for (int i = 0; i < NUM_CH; i++) begin
      v.ch[i] = raw[fi][i] - MIDSCALE; // Offset binary code minus midscale.
    end
    return v;
  endfunction

  // Serialiser model. Rise bit goes first and chip 1 lags by its skew.
  always @(posedge adc_clk) begin
    #1;
    for (int c = 0; c < NUM_CHIPS; c++) begin
      local_cyc = cyc - skew[c];
      if (!stream_on || local_cyc < 0) begin
        ddr_in[c] = '0;
      end else begin
        f   = local_cyc / CLKS_PER_FRAME;
        p   = local_cyc % CLKS_PER_FRAME;
        pat = (c == 0 && f == bad_frame) ? BAD_PATTERN : FRAME_PATTERN;
        ddr_in[c].frame_rise = pat[WORD_W-1-2*p];
        ddr_in[c].frame_fall = pat[WORD_W-2-2*p];
        for (int k = 0; k < CH_PER_CHIP; k++) begin
          w = frame_word(f, c * CH_PER_CHIP + k);
          ddr_in[c].data_rise[k] = w[WORD_W-1-2*p];
          ddr_in[c].data_fall[k] = w[WORD_W-2-2*p];
        end
        if (c == 0 && p == 0 && f < NUM_ROWS) begin
          chk.push_expected(expected_row(f));
        end
      end
    end
    if (stream_on) begin
      cyc++;
    end
  end

  always @(posedge adc_clk) begin
    if (bad_frame >= 0 && frame_locked[1] !== 1'b1) begin
      lock1_lost = 1'b1;
    end
  end

  initial begin
    #((NUM_ROWS + 60) * 60);
    $display("run stopped by the watchdog before the tests completed");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    fab_en     = 1'b1;
    ddr_in     = '0;
    stream_on  = 1'b0;
    compare_en = 1'b1;
    lock1_lost = 1'b0;
    cyc        = 0;
    bad_frame  = -1;
    skew[0]    = 0;
    skew[1]    = 2;
    rng        = 32'd64;

    // Edge codes, then walking ones, then random rows.
    for (int i = 0; i < NUM_CH; i++) begin
      raw[0][i] = 12'h000;
      raw[1][i] = 12'h800;
      raw[2][i] = 12'hFFF;
      raw[3][i] = 12'h7FF;
    end
    for (int r = 4; r < 16; r++) begin
      for (int i = 0; i < NUM_CH; i++) begin
        raw[r][i] = 12'h001 << ((r - 4 + i) % WORD_W);
      end
    end
    for (int r = 16; r < NUM_ROWS; r++) begin
      for (int i = 0; i < NUM_CH; i++) begin
        rng       = xorshift(rng);
        raw[r][i] = rng[WORD_W-1:0];
      end
    end

    repeat (16) @(posedge adc_clk);
    #1 rst_n = 1'b1;
    @(posedge adc_clk);
    chk.expect_bits("sample_valid", sample_valid, 0);
    chk.expect_bits("frame_locked", frame_locked, 0);
    chk.expect_bits("fifo_overflow", fifo_overflow, 0);
    stream_on = 1'b1;
    wait (frame_locked == 2'b11);
    chk.end_test("reset and lock");

    wait (chk.n_rows == NUM_ROWS);
    compare_en = 1'b0;
    chk.end_test("data rows with chip skew");

    @(posedge adc_clk);
    bad_frame = cyc / CLKS_PER_FRAME + 2;
    wait (frame_locked[0] == 1'b0);
    chk.expect_bits("frame_locked", frame_locked, 2'b10);
    wait (frame_locked[0] == 1'b1);
    @(posedge adc_clk);
    chk.expect_bits("frame_locked", frame_locked, 2'b11);
    chk.expect_bits("lock1_lost", lock1_lost, 0);
    chk.end_test("frame clock fault");

    fab_en = 1'b0;
    repeat (20 * CLKS_PER_FRAME) @(posedge adc_clk);
    chk.expect_bits("fifo_overflow", fifo_overflow, 2'b11);
    fab_en = 1'b1;
    repeat (5 * CLKS_PER_FRAME) @(posedge adc_clk);
    chk.expect_bits("fifo_overflow", fifo_overflow, 2'b11);
    #1 rst_n = 1'b0;
    #1;
    chk.expect_bits("fifo_overflow", fifo_overflow, 0);
    chk.expect_bits("sample_valid", sample_valid, 0);
    chk.end_test("overflow");

    chk.summary();
    if (chk.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
verilog/adc_rx_pkg.sv
verilog/adc_lane_deserialise.sv
verilog/adc_frame_monitor.sv
verilog/adc_retime_fifo.sv
verilog/adc_sample_align.sv
verilog/adc_rx_top.sv
dv/tb_clock_gen.sv
dv/adc_rx_checker.sv
dv/adc_rx_tb.sv

/* Bender.yml */
package:
  name: adc_rx

sources:
  - verilog/adc_rx_pkg.sv
  - verilog/adc_lane_deserialise.sv
  - verilog/adc_frame_monitor.sv
  - verilog/adc_retime_fifo.sv
  - verilog/adc_sample_align.sv
  - verilog/adc_rx_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/adc_rx_checker.sv
      - dv/adc_rx_tb.sv
